// ==== flist.f ====
rtl/mem_stage_pkg.sv
rtl/mem_request.sv
rtl/data_ram.sv
rtl/load_writeback.sv
rtl/mem_stage.sv
tb/mem_stage_properties.sv
tb/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mem_stage \
	--Mdir obj_dir -o sim_mem_stage \
	-f flist.f

if ! output=$(./obj_dir/sim_mem_stage 2>&1); then
	echo "$output"
	echo "Simulation exited with an error status"
	exit 1
fi

echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// ==== tb/tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage
	import mem_stage_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = 256;
	localparam int AW = $clog2(DEPTH);

	// Bundle counts per test that size the watchdog
	localparam int FILL_BUNDLES      = DEPTH;
	localparam int ROUNDTRIP_BUNDLES = 6;
	localparam int LANE_BUNDLES      = 22;
	localparam int BRANCH_BUNDLES    = 4;
	localparam int MISALIGN_BUNDLES  = 12;
	localparam int ALU_BUNDLES       = 4;
	localparam int RANDOM_BUNDLES    = 200;
	localparam int TOTAL_BUNDLES     = FILL_BUNDLES + ROUNDTRIP_BUNDLES + LANE_BUNDLES +
		BRANCH_BUNDLES + MISALIGN_BUNDLES + ALU_BUNDLES + RANDOM_BUNDLES;
	localparam int WATCHDOG_NS = (TOTAL_BUNDLES + 40) * 4 * 2;

	logic        clk;
	logic        reset;
	ex_mem_t     ex_mem;
	logic        pc_src;
	logic [31:0] pc_branch;
	mem_wb_t     mem_wb;

	logic [31:0] model_mem [DEPTH];
	logic [31:0] rng_state = 32'ha0f18f7b;
	int          mem_wb_errors = 0;
	int          branch_errors = 0;

	mem_stage #(
		.DEPTH(DEPTH)
	) DUT (
		.clk      (clk),
		.reset    (reset),
		.ex_mem   (ex_mem),
		.pc_src   (pc_src),
		.pc_branch(pc_branch),
		.mem_wb   (mem_wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic logic is_misaligned(input mem_size_e size, input logic [1:0] off);
		case (size)
			SIZE_BYTE: return 1'b0;
			SIZE_HALF: return off[0];
			default:   return off != 2'b00;
		endcase
	endfunction

	function automatic mem_wb_t predict_result(input ex_mem_t b);
		logic [1:0]    off;
		logic [AW-1:0] idx;
		logic          flt;
		logic [31:0]   word;
		logic [7:0]    v8;
		logic [15:0]   v16;
		logic [31:0]   ld;
		mem_wb_t       r;
		off  = b.alu_result[1:0];
		idx  = b.alu_result[AW+1:2];
		flt  = (b.mem.mem_read | b.mem.mem_write) & is_misaligned(b.mem.size, off);
		word = model_mem[idx];
		v8   = word[{off, 3'b000} +: 8];
		v16  = word[{off[1], 4'b0000} +: 16];
		case (b.mem.size)
			SIZE_BYTE: ld = b.mem.is_unsigned ? {24'b0, v8} : {{24{v8[7]}}, v8};
			SIZE_HALF: ld = b.mem.is_unsigned ? {16'b0, v16} : {{16{v16[15]}}, v16};
			default:   ld = word;
		endcase
		r.fault     = flt;
		r.write_reg = b.write_reg;
		if (flt && b.mem.mem_read)
		begin
			r.reg_write = 1'b0;
			r.wb_data   = 32'b0;
		end
		else
		begin
			r.reg_write = b.wb.reg_write;
			r.wb_data   = b.wb.mem_to_reg ? ld : b.alu_result;
		end
		return r;
	endfunction

	task automatic update_model(input ex_mem_t b);
		logic [1:0]    off;
		logic [AW-1:0] idx;
		off = b.alu_result[1:0];
		idx = b.alu_result[AW+1:2];
		if (b.mem.mem_write && !is_misaligned(b.mem.size, off))
		begin
			case (b.mem.size)
				SIZE_BYTE: model_mem[idx][{off, 3'b000} +: 8] = b.store_data[7:0];
				SIZE_HALF: model_mem[idx][{off[1], 4'b0000} +: 16] = b.store_data[15:0];
				default:   model_mem[idx] = b.store_data;
			endcase
		end
	endtask

	function automatic ex_mem_t access_bundle(input logic wr, input logic rd,
		input mem_size_e size, input logic uns, input logic [31:0] addr,
		input logic [31:0] data, input reg_addr_t dest);
		ex_mem_t b;
		b = '0;
		b.pc_branch       = next_random();
		b.zero            = b.pc_branch[5];
		b.alu_result      = addr;
		b.store_data      = data;
		b.write_reg       = dest;
		b.mem.mem_write   = wr;
		b.mem.mem_read    = rd;
		b.mem.is_unsigned = uns;
		b.mem.size        = size;
		b.wb.reg_write    = rd;
		b.wb.mem_to_reg   = rd;
		return b;
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_mem_wb(input mem_wb_t got, input mem_wb_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s: mem_wb reg_write=%0b write_reg=%0d wb_data=%h fault=%0b",
				$time, what, got.reg_write, got.write_reg, got.wb_data, got.fault);
			$display("  expected reg_write=%0b write_reg=%0d wb_data=%h fault=%0b",
				exp.reg_write, exp.write_reg, exp.wb_data, exp.fault);
			mem_wb_errors++;
		end
	endtask

	task automatic check_branch(input logic got_src, input logic [31:0] got_pc,
		input logic exp_src, input logic [31:0] exp_pc, input string what);
		if (got_src !== exp_src || got_pc !== exp_pc)
		begin
			$display("FAILED at %0t: %s: pc_src=%0b pc_branch=%h, expected pc_src=%0b pc_branch=%h",
				$time, what, got_src, got_pc, exp_src, exp_pc);
			branch_errors++;
		end
	endtask

	// Called one ns after an edge; returns one cycle later at the same phase
	task automatic run_bundle(input ex_mem_t b, input string what);
		mem_wb_t exp;
		exp = predict_result(b);
		update_model(b);
		ex_mem = b;
		#1;
		check_branch(pc_src, pc_branch, b.mem.branch & b.zero, b.pc_branch, what);
		@(posedge clk);
		#1;
		check_mem_wb(mem_wb, exp, what);
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic reset_state();
		check_mem_wb(mem_wb, '0, "after reset");
	endtask

	task automatic fill_ram();
		logic [31:0] addr;
		logic [31:0] pattern;
		for (int i = 0; i < DEPTH; i++)
		begin
			addr    = 32'(i) << 2;
			pattern = (32'(i) * 32'h9e3779b1) ^ 32'h13572468;
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, addr, pattern, 5'd0),
				$sformatf("fill word %0d", i));
		end
	endtask

	task automatic word_roundtrip();
		logic [31:0] r;
		logic [31:0] addr;
		for (int n = 0; n < 3; n++)
		begin
			r    = next_random();
			addr = {r[31:2], 2'b00};
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, addr, next_random(), 5'd0),
				$sformatf("roundtrip store %0d", n));
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_WORD, 1'b0, addr, 32'b0, r[6:2]),
				$sformatf("roundtrip load %0d", n));
		end
	endtask

	task automatic lane_loads();
		logic [31:0] base;
		logic [31:0] d;
		// Byte lanes with alternating sign bits
		base = 32'h0000_0028;
		run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, base, 32'b0, 5'd0), "byte base");
		for (int l = 0; l < 4; l++)
		begin
			d    = next_random();
			d[7] = ~l[0];
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_BYTE, 1'b0, base + 32'(l), d, 5'd0),
				$sformatf("byte store lane %0d", l));
		end
		for (int l = 0; l < 4; l++)
		begin
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_BYTE, 1'b0, base + 32'(l), 32'b0, 5'd3),
				$sformatf("signed byte load lane %0d", l));
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_BYTE, 1'b1, base + 32'(l), 32'b0, 5'd4),
				$sformatf("unsigned byte load lane %0d", l));
		end
		run_bundle(access_bundle(1'b0, 1'b1, SIZE_WORD, 1'b0, base, 32'b0, 5'd5), "byte word");

		// Half lanes
		base = 32'h0000_0050;
		run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, base, next_random(), 5'd0),
			"half base");
		for (int h = 0; h < 2; h++)
		begin
			d     = next_random();
			d[15] = ~h[0];
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_HALF, 1'b0, base + 32'(2 * h), d, 5'd0),
				$sformatf("half store %0d", h));
		end
		for (int h = 0; h < 2; h++)
		begin
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_HALF, 1'b0, base + 32'(2 * h), 32'b0, 5'd6),
				$sformatf("signed half load %0d", h));
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_HALF, 1'b1, base + 32'(2 * h), 32'b0, 5'd7),
				$sformatf("unsigned half load %0d", h));
		end
		run_bundle(access_bundle(1'b0, 1'b1, SIZE_WORD, 1'b0, base, 32'b0, 5'd8), "half word");
	endtask

	task automatic branch_resolve();
		ex_mem_t b;
		for (int k = 0; k < 4; k++)
		begin
			b = access_bundle(1'b0, 1'b0, SIZE_WORD, 1'b0, next_random(), 32'b0, 5'd9);
			b.mem.branch = k[1];
			b.zero       = k[0];
			run_bundle(b, $sformatf("branch=%0d zero=%0d", k[1], k[0]));
		end
	endtask

	task automatic misaligned_access();
		logic [31:0] base;
		logic [31:0] known;
		base  = 32'h0000_0100;
		known = 32'hc3a5_5a3c;
		run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, base, known, 5'd0), "known word");
		// Half at offsets 1 and 3, word at 1 to 3
		for (int o = 1; o < 4; o += 2)
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_HALF, 1'b0, base + 32'(o), ~known, 5'd0),
				$sformatf("misaligned half store %0d", o));
		for (int o = 1; o < 4; o++)
			run_bundle(access_bundle(1'b1, 1'b0, SIZE_WORD, 1'b0, base + 32'(o), ~known, 5'd0),
				$sformatf("misaligned word store %0d", o));
		for (int o = 1; o < 4; o += 2)
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_HALF, 1'b0, base + 32'(o), 32'b0, 5'd10),
				$sformatf("misaligned half load %0d", o));
		for (int o = 1; o < 4; o++)
			run_bundle(access_bundle(1'b0, 1'b1, SIZE_WORD, 1'b0, base + 32'(o), 32'b0, 5'd11),
				$sformatf("misaligned word load %0d", o));
		run_bundle(access_bundle(1'b0, 1'b1, SIZE_WORD, 1'b0, base, 32'b0, 5'd12),
			"word after misaligned");
	endtask

	task automatic alu_passthrough();
		ex_mem_t b;
		for (int k = 0; k < 4; k++)
		begin
			b = access_bundle(1'b0, 1'b0, SIZE_BYTE, 1'b0, next_random(), 32'b0, 5'(k + 13));
			b.wb.reg_write = 1'b1;
			// Unaligned address without strobes must not fault
			if (k == 3)
			begin
				b.mem.size         = SIZE_WORD;
				b.alu_result[1:0]  = 2'b11;
			end
			run_bundle(b, $sformatf("alu passthrough %0d", k));
		end
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		logic [31:0] addr;
		mem_size_e   size;
		for (int n = 0; n < RANDOM_BUNDLES; n++)
		begin
			r = next_random();
			case (r[2:1])
				2'd0:    size = SIZE_BYTE;
				2'd1:    size = SIZE_HALF;
				default: size = SIZE_WORD;
			endcase
			addr = next_random();
			if (size == SIZE_HALF)
				addr[0] = 1'b0;
			if (size == SIZE_WORD)
				addr[1:0] = 2'b00;
			run_bundle(access_bundle(r[0], ~r[0], size, r[3], addr, next_random(), r[8:4]),
				$sformatf("random %0d", n));
		end
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial
	begin
		ex_mem = '0;
		reset  = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_state();
		fill_ram();
		word_roundtrip();
		lane_loads();
		branch_resolve();
		misaligned_access();
		alu_passthrough();
		random_traffic();
		ex_mem = '0;
		@(posedge clk);
		#1;
		$display("Errors: mem_wb %0d, branch %0d", mem_wb_errors, branch_errors);
		if (mem_wb_errors + branch_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/mem_stage_properties.sv ====
`default_nettype none

module mem_stage_properties
	import mem_stage_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input ex_mem_t    ex_mem,
	input logic       pc_src,
	input logic       fault,
	input logic [3:0] ram_we,
	input mem_wb_t    mem_wb
);
	timeunit 1ns;
	timeprecision 1ps;

	logic access_misaligned;

	// Alignment rule taken straight from the incoming bundle
	assign access_misaligned = (ex_mem.mem.mem_read | ex_mem.mem.mem_write) &
		((ex_mem.mem.size == SIZE_HALF && ex_mem.alu_result[0]) ||
		(ex_mem.mem.size == SIZE_WORD && ex_mem.alu_result[1:0] != 2'b00));

	////////////////////
	// Reset
	////////////////////

	// Control bits of the MEM/WB register clear on the edge with reset high
	reset_clears_outputs: assert property (@(posedge clk)
		reset |=> (!mem_wb.reg_write && !mem_wb.fault))
		else $error("mem_wb control bits not cleared after reset");

	////////////////////
	// Branch and fault
	////////////////////

	branch_needs_bit: assert property (@(posedge clk)
		pc_src |-> ex_mem.mem.branch)
		else $error("pc_src high without the branch bit");

	// A misaligned access must fault and leave the RAM untouched
	fault_blocks_write: assert property (@(posedge clk)
		access_misaligned |-> (fault && ram_we == 4'b0000))
		else $error("misaligned access without fault or with byte enables active");

endmodule

bind mem_stage mem_stage_properties u_mem_stage_properties (
	.clk   (clk),
	.reset (reset),
	.ex_mem(ex_mem),
	.pc_src(pc_src),
	.fault (fault),
	.ram_we(ram_we),
	.mem_wb(mem_wb)
);

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none

module mem_stage
	import mem_stage_pkg::*;
#(
	parameter int DEPTH = 2048
)
(
	input  logic        clk,
	input  logic        reset,
	input  ex_mem_t     ex_mem,
	output logic        pc_src,
	output logic [31:0] pc_branch,
	output mem_wb_t     mem_wb
);

	logic                     ram_en;
	logic [3:0]               ram_we;
	logic [$clog2(DEPTH)-1:0] ram_addr;
	mem_word_u                ram_din;
	mem_word_u                ram_dout;
	load_info_t               load_info;
	logic                     fault;

	////////////////////
	// Request decode
	////////////////////

	mem_request #(
		.DEPTH(DEPTH)
	) u_mem_request (
		.ex_mem   (ex_mem),
		.ram_en   (ram_en),
		.ram_we   (ram_we),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.load_info(load_info),
		.fault    (fault),
		.pc_src   (pc_src),
		.pc_branch(pc_branch)
	);

	data_ram #(
		.DEPTH(DEPTH)
	) u_data_ram (
		.clk (clk),
		.en  (ram_en),
		.we  (ram_we),
		.addr(ram_addr),
		.din (ram_din),
		.dout(ram_dout)
	);

	// Write-back side lines up with the RAM read register
	load_writeback u_load_writeback (
		.clk       (clk),
		.reset     (reset),
		.load_info (load_info),
		.fault     (fault),
		.alu_result(ex_mem.alu_result),
		.write_reg (ex_mem.write_reg),
		.wb        (ex_mem.wb),
		.ram_dout  (ram_dout),
		.mem_wb    (mem_wb)
	);

endmodule

`default_nettype wire

// ==== rtl/load_writeback.sv ====
`default_nettype none

module load_writeback
	import mem_stage_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  load_info_t  load_info,
	input  logic        fault,
	input  logic [31:0] alu_result,
	input  reg_addr_t   write_reg,
	input  wb_ctrl_t    wb,
	input  mem_word_u   ram_dout,
	output mem_wb_t     mem_wb
);

	load_info_t  info_q;
	logic        fault_q;
	logic [31:0] alu_q;
	reg_addr_t   write_reg_q;
	wb_ctrl_t    wb_q;

	logic [7:0]  lane8;
	logic [15:0] lane16;
	logic [31:0] load_ext;
	logic        load_fault;

	////////////////////
	// MEM/WB register
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_q    <= '0;
			fault_q <= 1'b0;
			info_q  <= '0;
		end
		else
		begin
			wb_q    <= wb;
			fault_q <= fault;
			info_q  <= load_info;
		end
	end

	always_ff @(posedge clk)
	begin
		alu_q       <= alu_result;
		write_reg_q <= write_reg;
	end

	////////////////////
	// Lane extract and extend
	////////////////////

	assign lane8  = ram_dout.lane[info_q.byte_off];
	assign lane16 = ram_dout.half[info_q.byte_off[1]];

	always_comb
	begin
		case (info_q.size)
			SIZE_BYTE:
				load_ext = info_q.is_unsigned ? {24'b0, lane8} : {{24{lane8[7]}}, lane8};
			SIZE_HALF:
				load_ext = info_q.is_unsigned ? {16'b0, lane16} : {{16{lane16[15]}}, lane16};
			default:
				load_ext = ram_dout.word;
		endcase
	end

	// Misaligned load never reaches the register file
	assign load_fault = fault_q & info_q.is_load;

	assign mem_wb.reg_write = wb_q.reg_write & ~load_fault;
	assign mem_wb.write_reg = write_reg_q;
	assign mem_wb.wb_data   = load_fault      ? 32'b0 :
	                          wb_q.mem_to_reg ? load_ext : alu_q;
	assign mem_wb.fault     = fault_q;

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`default_nettype none

module data_ram
	import mem_stage_pkg::*;
#(
	parameter int DEPTH = 2048
)
(
	input  logic                     clk,
	input  logic                     en,
	input  logic [3:0]               we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  mem_word_u                din,
	output mem_word_u                dout
);

	mem_word_u mem [DEPTH];

	////////////////////
	// Byte-lane writes
	////////////////////

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (we[i])
			begin
				mem[addr].lane[i] <= din.lane[i];
			end
		end
	end

	////////////////////
	// Registered read
	////////////////////

	// Read before write on a shared address, output held when idle
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_request.sv ====
`default_nettype none

module mem_request
	import mem_stage_pkg::*;
#(
	parameter int DEPTH = 2048
)
(
	input  ex_mem_t                    ex_mem,
	output logic                       ram_en,
	output logic [3:0]                 ram_we,
	output logic [$clog2(DEPTH)-1:0]   ram_addr,
	output mem_word_u                  ram_din,
	output load_info_t                 load_info,
	output logic                       fault,
	output logic                       pc_src,
	output logic [31:0]                pc_branch
);

	localparam int AW = $clog2(DEPTH);

	logic [1:0] byte_off;
	logic       is_access;
	logic       misaligned;
	logic [3:0] lane_we;
	mem_word_u  store_word;

	assign byte_off  = ex_mem.alu_result[1:0];
	assign is_access = ex_mem.mem.mem_read | ex_mem.mem.mem_write;

	////////////////////
	// Alignment check
	////////////////////

	always_comb
	begin
		case (ex_mem.mem.size)
			SIZE_HALF: misaligned = byte_off[0];
			SIZE_WORD: misaligned = |byte_off;
			default:   misaligned = 1'b0;
		endcase
	end

	// Only a real memory access can fault
	assign fault = is_access & misaligned;

	////////////////////
	// Store lane placement
	////////////////////

	always_comb
	begin
		store_word.word = '0;
		lane_we = 4'b0000;
		case (ex_mem.mem.size)
			SIZE_BYTE:
			begin
				store_word.lane[byte_off] = ex_mem.store_data[7:0];
				lane_we[byte_off] = 1'b1;
			end
			SIZE_HALF:
			begin
				store_word.half[byte_off[1]] = ex_mem.store_data[15:0];
				lane_we = byte_off[1] ? 4'b1100 : 4'b0011;
			end
			default:
			begin
				store_word.word = ex_mem.store_data;
				lane_we = 4'b1111;
			end
		endcase
	end

	// Suppress the RAM entirely on a misaligned access
	assign ram_we   = (ex_mem.mem.mem_write & ~fault) ? lane_we : 4'b0000;
	assign ram_en   = ex_mem.mem.mem_read & ~fault;
	assign ram_addr = ex_mem.alu_result[AW+1:2];
	assign ram_din  = store_word;

	// Lane selection is repeated on the load side one cycle later
	assign load_info.is_load     = ex_mem.mem.mem_read;
	assign load_info.is_unsigned = ex_mem.mem.is_unsigned;
	assign load_info.size        = ex_mem.mem.size;
	assign load_info.byte_off    = byte_off;

	// Branch resolves in this stage
	assign pc_src    = ex_mem.mem.branch & ex_mem.zero;
	assign pc_branch = ex_mem.pc_branch;

endmodule

`default_nettype wire

// ==== rtl/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

	////////////////////
	// Access encoding
	////////////////////

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef logic [4:0] reg_addr_t;

	// One data word, seen whole, as halves or as byte lanes
	typedef union packed {
		logic [31:0]      word;
		logic [1:0][15:0] half;
		logic [3:0][7:0]  lane;
	} mem_word_u;

	////////////////////
	// Control bundles
	////////////////////

	typedef struct packed {
		logic      mem_write;
		logic      mem_read;
		logic      branch;
		logic      is_unsigned;
		mem_size_e size;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	////////////////////
	// Stage bundles
	////////////////////

	// From execute; alu_result doubles as the byte address
	typedef struct packed {
		logic [31:0] pc_branch;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic        zero;
		reg_addr_t   write_reg;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
	} ex_mem_t;

	typedef struct packed {
		logic        reg_write;
		reg_addr_t   write_reg;
		logic [31:0] wb_data;
		logic        fault;
	} mem_wb_t;

	// Handed from the request side to the load side
	typedef struct packed {
		logic      is_load;
		logic      is_unsigned;
		mem_size_e size;
		logic [1:0] byte_off;
	} load_info_t;

endpackage

`default_nettype wire
